/* rtl/frontend_pkg.sv */
// Instruction front-end definitions
package frontend_pkg;

    // Queue sizing
    localparam int unsigned IQ_ENTRIES = 8;
    localparam int unsigned IQ_PTR_W   = 3;            // log2 of IQ_ENTRIES
    localparam int unsigned IQ_CNT_W   = 4;            // One extra bit so full differs from empty

    // Fetch restarts here after reset
    localparam logic [31:0] BOOT_PC = 32'h0000_0100;

    // RV32I major opcodes, bits 6:0 of the instruction word
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_ALU_REG = 7'b0110011;

    // Widths that carry a meaning
    typedef logic [31:0]         addr_t;     // Instruction address
    typedef logic [31:0]         word_t;     // Raw instruction word
    typedef logic [4:0]          reg_idx_t;  // Architectural register index
    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;   // Head or tail pointer
    typedef logic [IQ_CNT_W-1:0] iq_cnt_t;   // Occupancy, 0 to IQ_ENTRIES

    // One slot of the instruction queue
    typedef struct packed {
        logic  valid;    // Entry carries a fetched word
        addr_t pc;       // Address the word was fetched from
        word_t instr;    // Fetched instruction
    } instr_entry_t;

    // Coarse instruction class seen by the back end
    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_ALU_IMM,
        CLS_ALU_REG,
        CLS_ILLEGAL
    } instr_class_e;

    // Decoded micro-op handed to the back end
    typedef struct packed {
        addr_t        pc;       // PC of the source instruction
        instr_class_e cls;      // Instruction class
        reg_idx_t     rd;       // Destination register
        reg_idx_t     rs1;      // First source register
        reg_idx_t     rs2;      // Second source register
        logic [2:0]   funct3;   // Minor opcode
        logic [31:0]  imm;      // Sign-extended immediate, zero if unused
    } uop_t;

endpackage

/* rtl/fetch_unit.sv */
// Sequential instruction fetch
module fetch_unit import frontend_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,

    input  logic         flush_i,       // Redirect fetch, kill in-flight request
    input  addr_t        flush_pc_i,    // New fetch address on flush

    input  iq_cnt_t      iq_count_i,    // Current queue occupancy

    output logic         imem_req_o,    // One-cycle request strobe
    output addr_t        imem_addr_o,   // Word address of the request
    input  word_t        imem_rdata_i,  // Data, one cycle after the request

    output instr_entry_t entry_o        // Queue write, valid bit is the strobe
);

    addr_t pc_q;          // Next address to fetch
    logic  inflight_q;    // A request went out last cycle
    addr_t req_pc_q;      // Address of that request

    // Occupancy including the request that has not landed yet
    logic [IQ_CNT_W:0] pending;
    logic              room;
    logic              issue;

    assign pending = {1'b0, iq_count_i} + {{IQ_CNT_W{1'b0}}, inflight_q};
    assign room    = (pending < IQ_ENTRIES);
    assign issue   = room & ~flush_i;   // Never fetch in the flush cycle

    assign imem_req_o  = issue;
    assign imem_addr_o = pc_q;

    // PC register
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= BOOT_PC;
        end else if (flush_i) begin
            pc_q <= flush_pc_i;          // Restart at the redirect target
        end else if (issue) begin
            pc_q <= pc_q + 32'd4;        // Next sequential word
        end
    end

    // In-flight tracking, the memory has no valid of its own
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= issue;         // Issue is already low during a flush
        end
    end

    // Request address travels alongside the response
    always_ff @(posedge clk_i) begin
        if (issue) begin
            req_pc_q <= pc_q;
        end
    end

    // Response lands in the queue unless a flush kills it this cycle
    always_comb begin
        entry_o       = '0;
        entry_o.valid = inflight_q & ~flush_i;
        entry_o.pc    = req_pc_q;
        entry_o.instr = imem_rdata_i;
    end

    // Occupancy accounting must keep the queue from overflowing
    a_no_write_when_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        entry_o.valid |-> (iq_count_i < IQ_ENTRIES)
    ) else $error("Queue written while holding %0d entries", iq_count_i);

endmodule

/* rtl/instruction_queue.sv */
// Circular instruction queue
module instruction_queue import frontend_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,

    input  logic         flush_i,       // Drop all entries
    input  instr_entry_t entry_i,       // Write at tail when valid
    input  logic         read_head_i,   // Pop request, a level

    output instr_entry_t entry_o,       // Popped head, all zero when no pop
    output iq_cnt_t      iq_count_o,    // Occupancy
    output logic         empty_o
);

    instr_entry_t buffer_q [IQ_ENTRIES];   // Storage, no reset needed

    iq_ptr_t head_q;    // Oldest entry
    iq_ptr_t tail_q;    // Next free slot
    iq_cnt_t count_q;   // Entries held

    logic write_en;
    logic read_en;

    // Every valid entry is written, fetch accounting keeps space free
    assign write_en = entry_i.valid;

    // Pop only stored data, and never while flushing
    assign read_en = read_head_i & (count_q != '0) & ~flush_i;

    // Tail write
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            buffer_q[tail_q] <= entry_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;                // Queue is empty at the next edge
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + iq_ptr_t'(read_en);    // Wraps at IQ_ENTRIES
            tail_q  <= tail_q + iq_ptr_t'(write_en);
            count_q <= count_q + iq_cnt_t'(write_en) - iq_cnt_t'(read_en);
        end
    end

    // Head is read combinationally in the pop cycle
    assign entry_o    = read_en ? buffer_q[head_q] : '0;
    assign iq_count_o = count_q;
    assign empty_o    = (count_q == '0);

    // Occupancy bound
    a_count_bound: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        count_q <= IQ_ENTRIES
    ) else $error("Queue occupancy %0d above capacity", count_q);

    // Equal pointers mean either empty or full, the counter decides which
    a_ptr_count_match: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (head_q == tail_q) |-> (empty_o || count_q == IQ_ENTRIES)
    ) else $error("Pointers and occupancy disagree");

    // An empty queue stays empty unless something is written
    a_empty_hold: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (empty_o && !write_en) |=> empty_o
    ) else $error("Queue left empty state without a write");

endmodule

/* rtl/instr_decoder.sv */
// RV32I instruction decoder
module instr_decoder import frontend_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,

    input  logic         flush_i,       // Suppress the next output
    input  logic         dec_ready_i,   // Back end can take a micro-op

    input  instr_entry_t entry_i,       // Popped queue head
    output logic         read_head_o,   // Pop request to the queue

    output uop_t         uop_o,         // Registered micro-op
    output logic         dec_valid_o    // Micro-op strobe
);

    word_t        instr;
    instr_class_e cls;
    logic [31:0]  imm_i;
    logic [31:0]  imm_s;
    logic [31:0]  imm_b;
    logic [31:0]  imm_u;
    logic [31:0]  imm_j;
    uop_t         uop_d;

    uop_t         uop_q;
    logic         valid_q;

    // The queue qualifies this with its own occupancy
    assign read_head_o = dec_ready_i;

    assign instr = entry_i.instr;

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Opcode to class
    always_comb begin
        cls = CLS_ILLEGAL;
        if (instr[1:0] == 2'b11) begin  // Compressed encodings are not supported
            case (instr[6:0])
                OPC_LUI:     cls = CLS_LUI;
                OPC_AUIPC:   cls = CLS_AUIPC;
                OPC_JAL:     cls = CLS_JAL;
                OPC_JALR:    cls = CLS_JALR;
                OPC_BRANCH:  cls = CLS_BRANCH;
                OPC_LOAD:    cls = CLS_LOAD;
                OPC_STORE:   cls = CLS_STORE;
                OPC_ALU_IMM: cls = CLS_ALU_IMM;
                OPC_ALU_REG: cls = CLS_ALU_REG;
                default:     cls = CLS_ILLEGAL;
            endcase
        end
    end

    // Field extraction and immediate select
    always_comb begin
        uop_d        = '0;
        uop_d.pc     = entry_i.pc;
        uop_d.cls    = cls;
        uop_d.rd     = instr[11:7];
        uop_d.rs1    = instr[19:15];
        uop_d.rs2    = instr[24:20];
        uop_d.funct3 = instr[14:12];
        case (cls)
            CLS_LUI, CLS_AUIPC:             uop_d.imm = imm_u;
            CLS_JAL:                        uop_d.imm = imm_j;
            CLS_JALR, CLS_LOAD, CLS_ALU_IMM: uop_d.imm = imm_i;
            CLS_BRANCH:                     uop_d.imm = imm_b;
            CLS_STORE:                      uop_d.imm = imm_s;
            default:                        uop_d.imm = '0;   // ALU_REG and illegal
        endcase
    end

    // Output strobe
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= entry_i.valid & ~flush_i;
        end
    end

    // Micro-op payload, loaded only on a pop
    always_ff @(posedge clk_i) begin
        if (entry_i.valid) begin
            uop_q <= uop_d;
        end
    end

    assign uop_o       = uop_q;
    assign dec_valid_o = valid_q;

    // Fetch only produces word-aligned PCs
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        dec_valid_o |-> (uop_o.pc[1:0] == 2'b00)
    ) else $error("Misaligned PC %h in decoded micro-op", uop_o.pc);

endmodule

/* rtl/frontend_top.sv */
// Instruction front-end top level
module frontend_top import frontend_pkg::*; (
    input  logic  clk_i,
    input  logic  rstn_i,

    // Redirect from the back end
    input  logic  flush_i,
    input  addr_t flush_pc_i,

    // Instruction memory, fixed one-cycle latency
    output logic  imem_req_o,
    output addr_t imem_addr_o,
    input  word_t imem_rdata_i,

    // Back-end handshake
    input  logic  dec_ready_i,
    output uop_t  uop_o,
    output logic  dec_valid_o
);

    instr_entry_t fetch_entry;   // Fetch to queue write
    instr_entry_t head_entry;    // Queue head to decoder
    iq_cnt_t      iq_count;      // Occupancy back to fetch
    logic         read_head;     // Decoder pop request

    // PC generation and memory requests
    fetch_unit i_fetch_unit (
        .clk_i        ( clk_i        ),
        .rstn_i       ( rstn_i       ),
        .flush_i      ( flush_i      ),
        .flush_pc_i   ( flush_pc_i   ),
        .iq_count_i   ( iq_count     ),
        .imem_req_o   ( imem_req_o   ),
        .imem_addr_o  ( imem_addr_o  ),
        .imem_rdata_i ( imem_rdata_i ),
        .entry_o      ( fetch_entry  )
    );

    // Decoupling buffer
    instruction_queue i_instruction_queue (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .flush_i     ( flush_i     ),
        .entry_i     ( fetch_entry ),
        .read_head_i ( read_head   ),
        .entry_o     ( head_entry  ),
        .iq_count_o  ( iq_count    ),
        .empty_o     (             )   // Fetch works from occupancy
    );

    // Decode stage
    instr_decoder i_instr_decoder (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .flush_i     ( flush_i     ),
        .dec_ready_i ( dec_ready_i ),
        .entry_i     ( head_entry  ),
        .read_head_o ( read_head   ),
        .uop_o       ( uop_o       ),
        .dec_valid_o ( dec_valid_o )
    );

endmodule

/* test/frontend_model.svh */
// Front-end reference model
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

localparam int MEM_WORDS = 256;

// LUI AUIPC JAL JALR BRANCH LOAD STORE OP-IMM OP
localparam logic [62:0] LEGAL_OPCODES = {7'h37, 7'h17, 7'h6F, 7'h67, 7'h63,
                                         7'h03, 7'h23, 7'h13, 7'h33};

word_t imem [MEM_WORDS];   // Instruction memory, word index is address bits 9:2
addr_t exp_pc;             // Next PC the back end should receive

function automatic word_t mem_word(input addr_t addr);
    return imem[addr[9:2]];    // Upper address bits alias
endfunction

// Class from the RV32I base opcode map
function automatic instr_class_e opcode_class(input word_t w);
    if (w[1:0] != 2'b11) return CLS_ILLEGAL;   // 16-bit encodings
    case (w[6:0])
        7'h37:   return CLS_LUI;
        7'h17:   return CLS_AUIPC;
        7'h6F:   return CLS_JAL;
        7'h67:   return CLS_JALR;
        7'h63:   return CLS_BRANCH;
        7'h03:   return CLS_LOAD;
        7'h23:   return CLS_STORE;
        7'h13:   return CLS_ALU_IMM;
        7'h33:   return CLS_ALU_REG;
        default: return CLS_ILLEGAL;
    endcase
endfunction

// Expected micro-op for one fetched word
function automatic uop_t decode_word(input addr_t pc, input word_t w);
    uop_t u;
    u        = '0;
    u.pc     = pc;
    u.cls    = opcode_class(w);
    u.rd     = w[11:7];
    u.rs1    = w[19:15];
    u.rs2    = w[24:20];
    u.funct3 = w[14:12];
    case (u.cls)
        CLS_LUI, CLS_AUIPC:              u.imm = {w[31:12], 12'h000};
        CLS_JAL:                         u.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        CLS_BRANCH:                      u.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        CLS_STORE:                       u.imm = {{21{w[31]}}, w[30:25], w[11:7]};
        CLS_JALR, CLS_LOAD, CLS_ALU_IMM: u.imm = {{21{w[31]}}, w[30:20]};
        default:                         u.imm = 32'h0;   // No immediate
    endcase
    return u;
endfunction

task automatic fill_memory();
    word_t w;
    int    k;
    for (k = 0; k < MEM_WORDS; k++) begin
        w = $urandom;
        if ($urandom_range(2) == 0) begin
            w[6:0] = LEGAL_OPCODES[7 * $urandom_range(8) +: 7];   // Forced legal opcode
        end
        imem[k] = w;
    end
endtask

`endif

/* test/tb_frontend.sv */
// Front-end testbench
module tb_frontend import frontend_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    SEED         = 33;
    localparam int    RESET_CYCLES = 5;
    localparam int    HOLD_CYCLES  = 40;
    localparam int    DRAIN_LIMIT  = 3 * IQ_ENTRIES;
    localparam int    PLANTED      = 16;               // Bad words placed for test 5
    localparam addr_t PLANT_PC     = 32'h0000_0A00;
    localparam int    TEST_CYCLES  = 60 + 200 + HOLD_CYCLES + DRAIN_LIMIT + 20 + 300 + 62;
    localparam int    WATCHDOG     = RESET_CYCLES + TEST_CYCLES + 200;

    logic  clk_i, rstn_i;
    logic  flush_i, dec_ready_i, imem_req_o, dec_valid_o;
    addr_t flush_pc_i, imem_addr_o;
    word_t imem_rdata_i;
    uop_t  uop_o;

    logic  rsp_pending;        // Request seen last cycle
    addr_t rsp_addr;
    addr_t next_req_pc;        // Expected fetch address
    int    errors = 0;
    int    outputs = 0;
    int    planted_seen = 0;
    int    req_total = 0;
    int    tests_run = 0;
    int    out_mark = 0;
    int    err_mark = 0;

    `include "frontend_model.svh"

    frontend_top i_frontend_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;    // 4 ns period
    end

    // Memory answers one cycle after each request
    always @(posedge clk_i) begin
        rsp_pending <= imem_req_o & rstn_i;
        rsp_addr    <= imem_addr_o;
    end

    always @(negedge clk_i) begin
        imem_rdata_i = rsp_pending ? mem_word(rsp_addr) : '0;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        assert (got === want) else begin
            $display("FAIL %0t ns %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    // Addresses that hold the words placed for test 5
    function automatic logic in_plant_region(input addr_t pc);
        return (pc >= PLANT_PC) && (pc < PLANT_PC + 4 * PLANTED);
    endfunction

    // Output and request monitor
    always @(posedge clk_i) begin
        uop_t want;
        if (rstn_i) begin
            if (dec_valid_o) begin
                want = decode_word(exp_pc, mem_word(exp_pc));
                check_value("uop_o", uop_o, want);
                if (in_plant_region(exp_pc) && uop_o.cls == CLS_ILLEGAL &&
                    uop_o.imm == '0) begin
                    planted_seen++;                // Bad word came out illegal, no immediate
                end
                exp_pc = exp_pc + 32'd4;
                outputs++;
            end
            assert (!(flush_i && imem_req_o)) else begin
                $display("Fetch issued a request during a flush at %0t ns", $time);
                errors++;
            end
            if (flush_i) begin
                exp_pc      = flush_pc_i;          // Both streams restart here
                next_req_pc = flush_pc_i;
            end else if (imem_req_o) begin
                check_value("imem_addr_o", imem_addr_o, next_req_pc);
                next_req_pc = next_req_pc + 32'd4;
                req_total++;
            end
        end
    end

    task automatic drive_cycles(input int n, input int ready_pct, input int flush_pm);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk_i);
            dec_ready_i = ($urandom_range(99) < ready_pct);
            flush_i     = ($urandom_range(999) < flush_pm);   // Per mille
            flush_pc_i  = $urandom & 32'hFFFF_FFFC;          // Word aligned
        end
    endtask

    task automatic plant_illegal_words();
        word_t      w;
        logic [7:0] slot;
        int         i;
        slot = PLANT_PC[9:2];
        for (i = 0; i < PLANTED; i++) begin
            w = $urandom;
            if (i % 2 == 0) begin
                w[1:0] = $urandom_range(2);                  // Low bits not 11
            end else begin
                w[1:0] = 2'b11;
                while (opcode_class(w) != CLS_ILLEGAL) w[6:2] = $urandom;
            end
            imem[slot] = w;
            slot++;
        end
    endtask

    task automatic close_test(input string name);
        assert (outputs > out_mark) else begin
            $display("%s delivered no micro-op", name);
            errors++;
        end
        $display("test %-28s micro-ops %4d  errors %0d", name, outputs - out_mark,
                 errors - err_mark);
        out_mark = outputs;
        err_mark = errors;
        tests_run++;
    endtask

    initial begin
        int i;
        int mark;
        void'($urandom(SEED));
        rstn_i       = 1'b0;
        flush_i      = 1'b0;
        flush_pc_i   = '0;
        dec_ready_i  = 1'b0;
        imem_rdata_i = '0;
        exp_pc       = BOOT_PC;
        next_req_pc  = BOOT_PC;
        fill_memory();
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;

        drive_cycles(60, 100, 0);
        close_test("1 ready held high");
        drive_cycles(200, 50, 0);
        close_test("2 random back-pressure");

        drive_cycles(HOLD_CYCLES / 2, 0, 0);
        mark = req_total;
        drive_cycles(HOLD_CYCLES / 2, 0, 0);
        assert (req_total == mark) else begin
            $display("Fetch kept requesting while the queue was full");
            errors++;
        end
        check_value("backlog", (next_req_pc - exp_pc) >> 2, IQ_ENTRIES);
        mark        = outputs;
        dec_ready_i = 1'b1;
        for (i = 0; i < DRAIN_LIMIT && outputs - mark < IQ_ENTRIES; i++) @(negedge clk_i);
        assert (outputs - mark >= IQ_ENTRIES) else begin
            $display("Held entries were not drained within %0d cycles", DRAIN_LIMIT);
            errors++;
        end
        drive_cycles(20, 100, 0);
        close_test("3 full queue hold and drain");

        drive_cycles(300, 70, 50);
        close_test("4 random flushes");

        mark = planted_seen;
        @(negedge clk_i);
        flush_i    = 1'b1;
        flush_pc_i = PLANT_PC;
        @(negedge clk_i);
        flush_i = 1'b0;
        plant_illegal_words();                  // Old stream can no longer reach this region
        drive_cycles(60, 100, 0);
        assert (planted_seen - mark == PLANTED) else begin
            $display("Planted words did not all come out as illegal");
            errors++;
        end
        close_test("5 illegal encodings");

        $display("tests %0d  micro-ops %0d  errors %0d", tests_run, outputs, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG) @(posedge clk_i);
        $display("Run did not finish within %0d cycles", WATCHDOG);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* files.f */
+incdir+test
rtl/frontend_pkg.sv
rtl/fetch_unit.sv
rtl/instruction_queue.sv
rtl/instr_decoder.sv
rtl/frontend_top.sv
test/tb_frontend.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - rtl/frontend_pkg.sv
  - rtl/fetch_unit.sv
  - rtl/instruction_queue.sv
  - rtl/instr_decoder.sv
  - rtl/frontend_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_frontend.sv
